/* logic/box_filter_config.svh */
`ifndef BOX_FILTER_CONFIG_SVH
`define BOX_FILTER_CONFIG_SVH

// number of pixels summed in one horizontal window.
`define BOX_WIN 12

// greyscale pixel width.
`define PIX_W 8

// image width and height, up to 511.
`define DIM_W 9

// pixel memory address, wide enough for 511 x 511.
`define ADDR_W 18

// window sum, 8 bits plus 4 bits of growth for 12 terms.
`define SUM_W 12

// column counter, one bit wider than a dimension.
`define CNT_W 10

// read latency of the external pixel memory in cycles.
`define MEM_LAT 1

`endif

/* logic/box_filter_pkg.sv */
`include "box_filter_config.svh"

package box_filter_pkg;

  typedef logic [`PIX_W-1:0] pixel_t;

  typedef logic [`DIM_W-1:0] dim_t;

  typedef logic [`CNT_W-1:0] col_cnt_t;

  typedef logic [`ADDR_W-1:0] addr_t;

  typedef logic [`SUM_W-1:0] box_sum_t;

  // row sequencer states.
  // each row walks START_ROW, SUM_EN, CUM_EN and back to START_ROW.
  typedef enum logic [2:0] {
    IDLE       = 3'b000,
    START      = 3'b001,
    START_ROW  = 3'b010,
    SUM_EN     = 3'b011,
    CUM_EN     = 3'b100,
    FINISH_ALL = 3'b101
  } box_state_e;

endpackage

/* logic/box_ctrl_if.sv */
`timescale 1ns/1ps

// enable strobes from the row sequencer to the counters and the datapath.
interface box_ctrl_if;

  logic start_en;
  logic count_en;
  logic ld_en;
  logic reset_en;
  logic sum_en;
  logic cum_en;

  modport ctrl (
    output start_en,
    output count_en,
    output ld_en,
    output reset_en,
    output sum_en,
    output cum_en
  );

  modport scan (
    input start_en,
    input count_en,
    input ld_en,
    input reset_en
  );

  modport acc (
    input ld_en,
    input reset_en,
    input sum_en,
    input cum_en
  );

endinterface

/* logic/box_filter_ctrl.sv */
`timescale 1ns/1ps
`include "box_filter_config.svh"

module box_filter_ctrl (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  box_filter_pkg::col_cnt_t counter_i,
  input  logic                     start_gt_2_i,
  input  logic                     row_eq_max_i,
  input  box_filter_pkg::dim_t     img_width_i,
  box_ctrl_if.ctrl                 ctl,
  output logic                     data_valid_o,
  output logic                     finish_o
);

  import box_filter_pkg::*;

  // the window is full once column 11 has been read.
  localparam col_cnt_t FILL_LAST = col_cnt_t'(`BOX_WIN - 1);

  box_state_e state_q;
  box_state_e prev_q;
  box_state_e state_d;
  col_cnt_t   row_last;

  // the counter runs one past the last column, so that the pixel of
  // column width-1 is still summed inside CUM_EN.
  assign row_last = col_cnt_t'(img_width_i) - 1'b1;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      prev_q  <= IDLE;
    end else begin
      state_q <= state_d;
      prev_q  <= state_q;
    end
  end

  always_comb begin
    case (state_q)
      IDLE:       state_d = start_i ? START : IDLE;
      START:      state_d = start_gt_2_i ? START_ROW : START;
      START_ROW:  state_d = SUM_EN;
      SUM_EN: begin
        if (row_eq_max_i) begin
          state_d = FINISH_ALL;
        end else if (counter_i > FILL_LAST) begin
          state_d = CUM_EN;
        end else begin
          state_d = SUM_EN;
        end
      end
      CUM_EN:     state_d = (counter_i > row_last) ? START_ROW : CUM_EN;
      FINISH_ALL: state_d = IDLE;
      default:    state_d = IDLE;
    endcase
  end

  always_comb begin
    ctl.start_en = 1'b0;
    ctl.count_en = 1'b0;
    ctl.ld_en    = 1'b0;
    ctl.reset_en = 1'b0;
    ctl.sum_en   = 1'b0;
    ctl.cum_en   = 1'b0;
    data_valid_o = 1'b0;
    finish_o     = 1'b0;

    case (state_q)
      START: begin
        ctl.start_en = 1'b1;
      end
      START_ROW: begin
        ctl.count_en = 1'b1;
        ctl.ld_en    = 1'b1;
        // the last sum of the row is still in the register here.
        if (prev_q == CUM_EN) begin
          data_valid_o = 1'b1;
        end
      end
      SUM_EN: begin
        ctl.count_en = 1'b1;
        ctl.sum_en   = 1'b1;
      end
      CUM_EN: begin
        ctl.count_en = 1'b1;
        ctl.sum_en   = 1'b1;
        ctl.cum_en   = 1'b1;
        data_valid_o = 1'b1;
      end
      FINISH_ALL: begin
        finish_o     = 1'b1;
        ctl.reset_en = 1'b1;
      end
      default: begin
      end
    endcase
  end

  a_finish_pulse: assert property (
    @(posedge clk) disable iff (!rst_n)
    finish_o |=> !finish_o
  );

  a_idle_quiet: assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q == IDLE) |-> !data_valid_o
  );

  a_state_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    state_q inside {IDLE, START, START_ROW, SUM_EN, CUM_EN, FINISH_ALL}
  );

endmodule

/* logic/pixel_scan.sv */
`timescale 1ns/1ps

module pixel_scan (
  input  logic                     clk,
  input  logic                     rst_n,
  input  box_filter_pkg::dim_t     img_width_i,
  input  box_filter_pkg::dim_t     img_height_i,
  box_ctrl_if.scan                 ctl,
  output logic                     rd_en_o,
  output box_filter_pkg::addr_t    rd_addr_o,
  output box_filter_pkg::col_cnt_t counter_o,
  output logic                     start_gt_2_o,
  output logic                     row_eq_max_o
);

  import box_filter_pkg::*;

  logic [1:0] start_cnt;
  logic       first_row;
  dim_t       row_idx;
  addr_t      row_base;
  col_cnt_t   col_q;
  logic       col_in_row;

  assign col_in_row = col_q < col_cnt_t'(img_width_i);

  // START_ROW holds a stale column, so no read is made in it.
  // after the last row the SUM_EN cycle that ends the frame reads nothing.
  assign rd_en_o = ctl.count_en && !ctl.ld_en && col_in_row && !row_eq_max_o;

  assign rd_addr_o = row_base + addr_t'(col_q);

  assign counter_o = col_q;

  // high in the third warm-up cycle.
  assign start_gt_2_o = start_cnt == 2'd2;

  assign row_eq_max_o = row_idx == img_height_i;

  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      start_cnt <= '0;
      first_row <= 1'b0;
    end else begin
      if (ctl.start_en && !start_gt_2_o) begin
        start_cnt <= start_cnt + 1'b1;
      end
      if (ctl.start_en) begin
        first_row <= 1'b1;
      end else if (ctl.ld_en) begin
        first_row <= 1'b0;
      end
    end
  end

  // every START_ROW but the first one steps to the next image row.
  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      row_idx  <= '0;
      row_base <= '0;
    end else if (ctl.ld_en && !first_row) begin
      row_idx  <= row_idx + 1'b1;
      row_base <= row_base + addr_t'(img_width_i);
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctl.reset_en) begin
      col_q <= '0;
    end else if (ctl.ld_en) begin
      col_q <= '0;
    end else if (ctl.count_en) begin
      col_q <= col_q + 1'b1;
    end
  end

  a_addr_in_image: assert property (
    @(posedge clk) disable iff (!rst_n)
    rd_en_o |-> (rd_addr_o < addr_t'(img_width_i) * addr_t'(img_height_i))
  );

endmodule

/* logic/window_sum.sv */
`timescale 1ns/1ps
`include "box_filter_config.svh"

module window_sum (
  input  logic                     clk,
  input  logic                     rst_n,
  input  box_filter_pkg::pixel_t   rd_data_i,
  box_ctrl_if.acc                  ctl,
  output box_filter_pkg::box_sum_t sum_o
);

  import box_filter_pkg::*;

  localparam int unsigned MAX_SUM = `BOX_WIN * ((1 << `PIX_W) - 1);

  logic [`MEM_LAT-1:0] sum_en_pipe;
  logic                pix_arrives;
  pixel_t              line_q [`BOX_WIN];
  pixel_t              oldest;
  box_sum_t            sum_q;
  box_sum_t            sum_d;

  // sum_en marks the cycle of a read, the pixel shows up MEM_LAT later.
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_en_pipe <= '0;
    end else begin
      sum_en_pipe[0] <= ctl.sum_en;
      for (int i = 1; i < `MEM_LAT; i++) begin
        sum_en_pipe[i] <= sum_en_pipe[i-1];
      end
    end
  end

  assign pix_arrives = sum_en_pipe[`MEM_LAT-1];

  assign oldest = line_q[`BOX_WIN-1];

  // cum_en already lines up with the pixel of column 12 onwards.
  always_comb begin
    sum_d = sum_q;
    if (pix_arrives) begin
      if (ctl.cum_en) begin
        sum_d = sum_q + box_sum_t'(rd_data_i) - box_sum_t'(oldest);
      end else begin
        sum_d = sum_q + box_sum_t'(rd_data_i);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || ctl.ld_en || ctl.reset_en) begin
      sum_q <= '0;
    end else begin
      sum_q <= sum_d;
    end
  end

  // line_q[0] holds the newest pixel.
  always_ff @(posedge clk) begin
    if (ctl.ld_en || ctl.reset_en) begin
      for (int i = 0; i < `BOX_WIN; i++) begin
        line_q[i] <= '0;
      end
    end else if (pix_arrives) begin
      line_q[0] <= rd_data_i;
      for (int i = 1; i < `BOX_WIN; i++) begin
        line_q[i] <= line_q[i-1];
      end
    end
  end

  assign sum_o = sum_q;

  a_sum_in_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sum_q <= box_sum_t'(MAX_SUM)
  );

endmodule

/* logic/box_filter_top.sv */
`timescale 1ns/1ps

module box_filter_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     start_i,
  input  box_filter_pkg::dim_t     img_width_i,
  input  box_filter_pkg::dim_t     img_height_i,
  input  box_filter_pkg::pixel_t   rd_data_i,
  output logic                     rd_en_o,
  output box_filter_pkg::addr_t    rd_addr_o,
  output box_filter_pkg::box_sum_t sum_o,
  output logic                     data_valid_o,
  output logic                     finish_o
);

  import box_filter_pkg::*;

  col_cnt_t counter;
  logic     start_gt_2;
  logic     row_eq_max;

  box_ctrl_if ctl_if ();

  // row sequencer.
  box_filter_ctrl i_ctrl (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .counter_i    (counter),
    .start_gt_2_i (start_gt_2),
    .row_eq_max_i (row_eq_max),
    .img_width_i  (img_width_i),
    .ctl          (ctl_if.ctrl),
    .data_valid_o (data_valid_o),
    .finish_o     (finish_o)
  );

  // counters and memory addressing.
  pixel_scan i_scan (
    .clk          (clk),
    .rst_n        (rst_n),
    .img_width_i  (img_width_i),
    .img_height_i (img_height_i),
    .ctl          (ctl_if.scan),
    .rd_en_o      (rd_en_o),
    .rd_addr_o    (rd_addr_o),
    .counter_o    (counter),
    .start_gt_2_o (start_gt_2),
    .row_eq_max_o (row_eq_max)
  );

  // delay line and running sum.
  window_sum i_sum (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_data_i (rd_data_i),
    .ctl       (ctl_if.acc),
    .sum_o     (sum_o)
  );

endmodule

/* sim/box_filter_tb.sv */
`timescale 1ns/1ps

module box_filter_tb;

  import box_filter_pkg::*;

  localparam int WIN = 12;
  localparam int MAX_PIX = 1024;
  // each frame costs its pixel count plus about 20 cycles per row.
  localparam int FRAME_CYCLES = (16 * 2 + 20 * 2) + (20 * 3 + 20 * 3) + (13 * 2 + 20 * 2)
    + (24 * 2 + 20 * 2) + (14 * 3 + 20 * 3) + (31 * 2 + 20 * 2);
  localparam int WATCHDOG_NS = (FRAME_CYCLES + 6 * 20 + 50) * 8;

  logic     clk;
  logic     rst_n;
  logic     start_i;
  dim_t     img_width_i;
  dim_t     img_height_i;
  pixel_t   rd_data_i;
  logic     rd_en_o;
  addr_t    rd_addr_o;
  box_sum_t sum_o;
  logic     data_valid_o;
  logic     finish_o;

  pixel_t      img [MAX_PIX];
  int          reads [MAX_PIX];
  box_sum_t    expected_q [$];
  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          sums_seen;
  int          finishes_seen;
  logic        pend_en;
  int          pend_idx;

  box_filter_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .start_i      (start_i),
    .img_width_i  (img_width_i),
    .img_height_i (img_height_i),
    .rd_data_i    (rd_data_i),
    .rd_en_o      (rd_en_o),
    .rd_addr_o    (rd_addr_o),
    .sum_o        (sum_o),
    .data_valid_o (data_valid_o),
    .finish_o     (finish_o)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string what, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, actual, expected);
    end
  endtask

  // the pixel memory returns data one cycle after a read.
  always begin
    @(negedge clk);
    pend_en = rd_en_o;
    pend_idx = int'(rd_addr_o);
    if (pend_en) begin
      if (pend_idx < int'(img_width_i) * int'(img_height_i)) begin
        reads[pend_idx] = reads[pend_idx] + 1;
      end else begin
        errors++;
        $display("Read address %0d at %0t lies outside the image", pend_idx, $time);
        pend_en = 1'b0;
      end
    end
    @(posedge clk);
    #1;
    if (pend_en) begin
      rd_data_i = img[pend_idx];
    end
  end

  always @(negedge clk) begin
    if (rst_n && data_valid_o) begin
      sums_seen++;
      if (expected_q.size() == 0) begin
        errors++;
        $display("A sum of %0d came out at %0t with no sum left to expect", sum_o, $time);
      end else begin
        check_value("window sum", 32'(sum_o), 32'(expected_q.pop_front()));
      end
    end
    if (rst_n && finish_o) begin
      finishes_seen++;
    end
  end

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  task automatic fill_image(input int w, input int h, input bit rand_fill, input pixel_t value);
    pixel_t p;
    for (int a = 0; a < w * h; a++) begin
      p = value;
      if (rand_fill) begin
        for (int b = 0; b < 8; b++) begin
          lfsr_state = lfsr_step(lfsr_state);
          p[b] = lfsr_state[0];
        end
      end
      img[a] = p;
    end
  endtask

  // every window of 12 pixels that ends in column 11 or later.
  task automatic build_expected(input int w, input int h);
    int total;
    for (int r = 0; r < h; r++) begin
      for (int j = WIN - 1; j < w; j++) begin
        total = 0;
        for (int k = j - WIN + 1; k <= j; k++) begin
          total += int'(img[r * w + k]);
        end
        expected_q.push_back(box_sum_t'(total));
      end
    end
  endtask

  task automatic run_frame(input int w, input int h);
    int fin_before;
    int sums_before;
    for (int a = 0; a < MAX_PIX; a++) begin
      reads[a] = 0;
    end
    fin_before = finishes_seen;
    sums_before = sums_seen;
    @(posedge clk);
    #1;
    img_width_i = dim_t'(w);
    img_height_i = dim_t'(h);
    start_i = 1'b1;
    @(posedge clk);
    #1;
    start_i = 1'b0;
    while (finishes_seen == fin_before) begin
      @(negedge clk);
    end
    repeat (5) @(negedge clk);
    check_value("finish pulses", finishes_seen - fin_before, 1);
    check_value("sum count", sums_seen - sums_before, h * (w - WIN + 1));
    check_value("sums still expected", expected_q.size(), 0);
    for (int a = 0; a < w * h; a++) begin
      check_value("reads of one address", reads[a], 1);
    end
    expected_q.delete();
  endtask

  task automatic report_test(input string name, input int errors_before);
    $display("test %s done with %0d errors", name, errors - errors_before);
  endtask

  task automatic quiet_after_reset();
    int e0;
    e0 = errors;
    repeat (10) begin
      @(negedge clk);
      check_value("rd_en_o after reset", 32'(rd_en_o), 0);
      check_value("data_valid_o after reset", 32'(data_valid_o), 0);
      check_value("finish_o after reset", 32'(finish_o), 0);
    end
    report_test("reset_quiet", e0);
  endtask

  task automatic constant_image_sums();
    int e0;
    e0 = errors;
    fill_image(16, 2, 1'b0, 8'd10);
    for (int i = 0; i < 10; i++) begin
      expected_q.push_back(box_sum_t'(120));
    end
    run_frame(16, 2);
    report_test("constant_image", e0);
  endtask

  task automatic random_image_sums();
    int e0;
    e0 = errors;
    fill_image(20, 3, 1'b1, 8'd0);
    build_expected(20, 3);
    run_frame(20, 3);
    report_test("random_image", e0);
  endtask

  task automatic min_width_full_scale();
    int e0;
    e0 = errors;
    fill_image(13, 2, 1'b0, 8'd255);
    for (int i = 0; i < 4; i++) begin
      expected_q.push_back(box_sum_t'(3060));
    end
    run_frame(13, 2);
    report_test("min_width_full_scale", e0);
  endtask

  task automatic back_to_back_frames();
    int e0;
    e0 = errors;
    fill_image(24, 2, 1'b1, 8'd0);
    build_expected(24, 2);
    run_frame(24, 2);
    fill_image(14, 3, 1'b1, 8'd0);
    build_expected(14, 3);
    run_frame(14, 3);
    report_test("back_to_back", e0);
  endtask

  // the memory model checks the address range and the read count.
  task automatic address_coverage();
    int e0;
    e0 = errors;
    fill_image(31, 2, 1'b1, 8'd0);
    build_expected(31, 2);
    run_frame(31, 2);
    report_test("address_coverage", e0);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, a frame never finished", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    start_i = 1'b0;
    img_width_i = dim_t'(16);
    img_height_i = dim_t'(2);
    rd_data_i = '0;
    lfsr_state = 32'd66413;
    checks = 0;
    errors = 0;
    sums_seen = 0;
    finishes_seen = 0;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    quiet_after_reset();
    constant_image_sums();
    random_image_sums();
    min_width_full_scale();
    back_to_back_frames();
    address_coverage();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* box_filter_top.f */
+incdir+logic
logic/box_filter_pkg.sv
logic/box_ctrl_if.sv
logic/box_filter_ctrl.sv
logic/pixel_scan.sv
logic/window_sum.sv
logic/box_filter_top.sv
sim/box_filter_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
  -f box_filter_top.f \
  --top-module box_filter_tb \
  -o box_filter_sim

output="$(./obj_dir/box_filter_sim)"
echo "$output"

if grep -qx "TESTBENCH PASSED" <<< "$output"; then
  exit 0
else
  exit 1
fi
